/* source/calc_cmd_pkg.sv */
/* Command format shared by the priority stage: opcodes, field types,
   the per-port command, the queued entry and the invalid-op response. */
`default_nettype none

package calc_cmd_pkg;

   typedef logic [3:0]  opcode_t;
   typedef logic [1:0]  req_tag_t;
   typedef logic [1:0]  port_id_t;
   typedef logic [31:0] operand_t;

   localparam opcode_t OP_NONE = 4'd0;
   localparam opcode_t OP_ADD  = 4'd1;
   localparam opcode_t OP_SUB  = 4'd2;
   localparam opcode_t OP_SHL  = 4'd5;
   localparam opcode_t OP_SHR  = 4'd6;

   // one command as presented on a requester port
   typedef struct packed {
      opcode_t  opcode;
      req_tag_t tag;
      operand_t data1;
      operand_t data2;
   } port_cmd_t;

   // port and tag together form the 4-bit tag seen by the units
   typedef struct packed {
      opcode_t  opcode;
      port_id_t port;
      req_tag_t tag;
      operand_t data1;
      operand_t data2;
   } queue_entry_t;

   typedef struct packed {
      logic     valid;
      req_tag_t tag;
   } invalid_rsp_t;

endpackage

`default_nettype wire

/* source/prio_cfg_pkg.sv */
/* Sizing of the priority stage: port count, queue depth and the
   count, slot and mask types derived from them. */
`default_nettype none

package prio_cfg_pkg;

   localparam int NUM_PORTS   = 4;
   localparam int QUEUE_DEPTH = 16;

   // a count must reach QUEUE_DEPTH itself, hence one extra bit
   typedef logic [$clog2(QUEUE_DEPTH):0]   count_t;
   typedef logic [$clog2(QUEUE_DEPTH)-1:0] slot_t;
   typedef logic [NUM_PORTS-1:0]           port_mask_t;

endpackage

`default_nettype wire

/* source/cmd_sorter.sv */
/* Classifies the four port commands into add, shift or invalid, builds
   the queue entries and registers the invalid-op responses. */
`timescale 1ns/1ps
`default_nettype none

module cmd_sorter (
   input  wire                          c_clk,
   input  wire                          arst_n,
   input  wire calc_cmd_pkg::port_cmd_t port_cmd [prio_cfg_pkg::NUM_PORTS],
   output logic                         cmd_ready,
   input  wire                          add_room,
   input  wire                          shift_room,
   output prio_cfg_pkg::port_mask_t     add_wr_mask,
   output prio_cfg_pkg::port_mask_t     shift_wr_mask,
   output calc_cmd_pkg::queue_entry_t   wr_entry [prio_cfg_pkg::NUM_PORTS],
   output calc_cmd_pkg::invalid_rsp_t   invalid_rsp [prio_cfg_pkg::NUM_PORTS]
);

   prio_cfg_pkg::port_mask_t is_add;
   prio_cfg_pkg::port_mask_t is_shift;
   prio_cfg_pkg::port_mask_t is_invalid;

   // both queues must be able to absorb a full cycle of commands
   assign cmd_ready = add_room && shift_room;

   always_comb begin
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         is_add[k]   = (port_cmd[k].opcode == calc_cmd_pkg::OP_ADD) ||
                       (port_cmd[k].opcode == calc_cmd_pkg::OP_SUB);
         is_shift[k] = (port_cmd[k].opcode == calc_cmd_pkg::OP_SHL) ||
                       (port_cmd[k].opcode == calc_cmd_pkg::OP_SHR);
         is_invalid[k] = (port_cmd[k].opcode != calc_cmd_pkg::OP_NONE) &&
                         !is_add[k] && !is_shift[k];

         wr_entry[k].opcode = port_cmd[k].opcode;
         wr_entry[k].port   = calc_cmd_pkg::port_id_t'(k);
         wr_entry[k].tag    = port_cmd[k].tag;
         wr_entry[k].data1  = port_cmd[k].data1;
         wr_entry[k].data2  = port_cmd[k].data2;
      end
   end

   // nothing is written while the ports are held off
   assign add_wr_mask   = cmd_ready ? is_add : '0;
   assign shift_wr_mask = cmd_ready ? is_shift : '0;

   // the response is valid for exactly one cycle after acceptance
   always_ff @(posedge c_clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
            invalid_rsp[k] <= '0;
         end
      end else begin
         for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
            invalid_rsp[k].valid <= cmd_ready && is_invalid[k];
            invalid_rsp[k].tag   <= port_cmd[k].tag;
         end
      end
   end

endmodule

`default_nettype wire

/* source/cmd_queue.sv */
/* Circular command queue of QUEUE_DEPTH entries. Up to one write per port
   and one pop per cycle; instantiated once for add and once for shift. */
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
   input  wire                             c_clk,
   input  wire                             arst_n,
   input  wire prio_cfg_pkg::port_mask_t   wr_mask,
   input  wire calc_cmd_pkg::queue_entry_t wr_entry [prio_cfg_pkg::NUM_PORTS],
   output logic                            room,
   output calc_cmd_pkg::queue_entry_t      head,
   output logic                            head_valid,
   input  wire                             pop
);

   calc_cmd_pkg::queue_entry_t mem [prio_cfg_pkg::QUEUE_DEPTH];

   prio_cfg_pkg::slot_t  rd_ptr;
   prio_cfg_pkg::count_t count;
   prio_cfg_pkg::count_t wr_num;
   prio_cfg_pkg::slot_t  wr_slot [prio_cfg_pkg::NUM_PORTS];

   // masked entries are packed onto consecutive tail slots in port order
   always_comb begin
      wr_num = '0;
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         wr_slot[k] = rd_ptr + prio_cfg_pkg::slot_t'(count) + prio_cfg_pkg::slot_t'(wr_num);
         wr_num     = wr_num + prio_cfg_pkg::count_t'(wr_mask[k]);
      end
   end

   always_ff @(posedge c_clk) begin
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         if (wr_mask[k]) begin
            mem[wr_slot[k]] <= wr_entry[k];
         end
      end
   end

   // the tail does not move on a pop, so writes and a pop can share an edge
   always_ff @(posedge c_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + wr_num - prio_cfg_pkg::count_t'(pop);
      end
   end

   assign head       = mem[rd_ptr];
   assign head_valid = (count != '0);
   assign room       = (count <= prio_cfg_pkg::count_t'(prio_cfg_pkg::QUEUE_DEPTH -
                                                       prio_cfg_pkg::NUM_PORTS));

   a_count_in_range : assert property (
      @(posedge c_clk) disable iff (!arst_n)
      count <= prio_cfg_pkg::count_t'(prio_cfg_pkg::QUEUE_DEPTH)
   );

   a_no_pop_when_empty : assert property (
      @(posedge c_clk) disable iff (!arst_n)
      pop |-> head_valid
   );

endmodule

`default_nettype wire

/* source/dispatch_arbiter.sv */
/* Offers the add and shift queue heads to their units with valid/ready.
   Heads from the same port leave one at a time, alternating between units. */
`timescale 1ns/1ps
`default_nettype none

module dispatch_arbiter (
   input  wire                             c_clk,
   input  wire                             arst_n,
   input  wire calc_cmd_pkg::queue_entry_t add_head,
   input  wire                             add_head_valid,
   input  wire calc_cmd_pkg::queue_entry_t shift_head,
   input  wire                             shift_head_valid,
   output logic                            add_pop,
   output logic                            shift_pop,
   output calc_cmd_pkg::queue_entry_t      add_out,
   output logic                            add_valid,
   output calc_cmd_pkg::queue_entry_t      shift_out,
   output logic                            shift_valid,
   input  wire                             add_ready,
   input  wire                             shift_ready
);

   typedef enum logic {
      TURN_ADD,
      TURN_SHIFT
   } turn_e;

   turn_e turn;
   logic  add_held;
   logic  shift_held;
   logic  conflict;

   assign conflict = add_head_valid && shift_head_valid &&
                     (add_head.port == shift_head.port);

   // a pending offer is kept until taken, even if a same-port head shows up
   assign add_valid = add_head_valid &&
                      (!conflict || add_held || (!shift_held && turn == TURN_ADD));
   assign shift_valid = shift_head_valid &&
                        (!conflict || shift_held || (!add_held && turn == TURN_SHIFT));

   // heads only change on a pop, so the outputs hold while stalled
   assign add_out   = add_head;
   assign shift_out = shift_head;

   assign add_pop   = add_valid && add_ready;
   assign shift_pop = shift_valid && shift_ready;

   always_ff @(posedge c_clk or negedge arst_n) begin
      if (!arst_n) begin
         turn       <= TURN_ADD;
         add_held   <= 1'b0;
         shift_held <= 1'b0;
      end else begin
         add_held   <= add_valid && !add_ready;
         shift_held <= shift_valid && !shift_ready;
         case (turn)
            TURN_ADD:   if (conflict && add_pop) turn <= TURN_SHIFT;
            TURN_SHIFT: if (conflict && shift_pop) turn <= TURN_ADD;
            default:    turn <= TURN_ADD;
         endcase
      end
   end

   a_no_same_port_pair : assert property (
      @(posedge c_clk) disable iff (!arst_n)
      !(add_valid && shift_valid && add_out.port == shift_out.port)
   );

   a_add_offer_stable : assert property (
      @(posedge c_clk) disable iff (!arst_n)
      add_valid && !add_ready |=> add_valid && $stable(add_out)
   );

endmodule

`default_nettype wire

/* source/prio_top.sv */
/* Top of the priority stage. Connects the sorter, the add and shift
   queues and the dispatch arbiter. */
`timescale 1ns/1ps
`default_nettype none

module prio_top (
   input  wire                          c_clk,
   input  wire                          arst_n,
   input  wire calc_cmd_pkg::port_cmd_t port_cmd [prio_cfg_pkg::NUM_PORTS],
   output logic                         cmd_ready,
   output calc_cmd_pkg::invalid_rsp_t   invalid_rsp [prio_cfg_pkg::NUM_PORTS],
   output calc_cmd_pkg::queue_entry_t   add_out,
   output logic                         add_valid,
   output calc_cmd_pkg::queue_entry_t   shift_out,
   output logic                         shift_valid,
   input  wire                          add_ready,
   input  wire                          shift_ready
);

   prio_cfg_pkg::port_mask_t   add_wr_mask;
   prio_cfg_pkg::port_mask_t   shift_wr_mask;
   calc_cmd_pkg::queue_entry_t wr_entry [prio_cfg_pkg::NUM_PORTS];

   logic                       add_room;
   logic                       shift_room;
   calc_cmd_pkg::queue_entry_t add_head;
   calc_cmd_pkg::queue_entry_t shift_head;
   logic                       add_head_valid;
   logic                       shift_head_valid;
   logic                       add_pop;
   logic                       shift_pop;

   cmd_sorter u_sorter (
      .c_clk         (c_clk),
      .arst_n        (arst_n),
      .port_cmd      (port_cmd),
      .cmd_ready     (cmd_ready),
      .add_room      (add_room),
      .shift_room    (shift_room),
      .add_wr_mask   (add_wr_mask),
      .shift_wr_mask (shift_wr_mask),
      .wr_entry      (wr_entry),
      .invalid_rsp   (invalid_rsp)
   );

   cmd_queue u_add_queue (
      .c_clk      (c_clk),
      .arst_n     (arst_n),
      .wr_mask    (add_wr_mask),
      .wr_entry   (wr_entry),
      .room       (add_room),
      .head       (add_head),
      .head_valid (add_head_valid),
      .pop        (add_pop)
   );

   cmd_queue u_shift_queue (
      .c_clk      (c_clk),
      .arst_n     (arst_n),
      .wr_mask    (shift_wr_mask),
      .wr_entry   (wr_entry),
      .room       (shift_room),
      .head       (shift_head),
      .head_valid (shift_head_valid),
      .pop        (shift_pop)
   );

   dispatch_arbiter u_arbiter (
      .c_clk            (c_clk),
      .arst_n           (arst_n),
      .add_head         (add_head),
      .add_head_valid   (add_head_valid),
      .shift_head       (shift_head),
      .shift_head_valid (shift_head_valid),
      .add_pop          (add_pop),
      .shift_pop        (shift_pop),
      .add_out          (add_out),
      .add_valid        (add_valid),
      .shift_out        (shift_out),
      .shift_valid      (shift_valid),
      .add_ready        (add_ready),
      .shift_ready      (shift_ready)
   );

endmodule

`default_nettype wire

/* sim/prio_tb.sv */
/* Testbench for the priority stage. Replays sim/prio_tests.txt on the four ports,
   keeps one expected queue per unit and checks every issue and invalid-op response. */
`timescale 1ns/1ps
`default_nettype none

module prio_tb;

   localparam int MAX_LINES = 64;

   logic                       c_clk;
   logic                       arst_n;
   calc_cmd_pkg::port_cmd_t    port_cmd [prio_cfg_pkg::NUM_PORTS];
   logic                       cmd_ready;
   calc_cmd_pkg::invalid_rsp_t invalid_rsp [prio_cfg_pkg::NUM_PORTS];
   calc_cmd_pkg::queue_entry_t add_out;
   logic                       add_valid;
   calc_cmd_pkg::queue_entry_t shift_out;
   logic                       shift_valid;
   logic                       add_ready;
   logic                       shift_ready;

   calc_cmd_pkg::port_cmd_t    line_cmd [MAX_LINES][prio_cfg_pkg::NUM_PORTS];
   logic [1:0]                 line_rdy [MAX_LINES][2];
   int                         num_lines = 0;
   int                         cycle_count = 0;
   calc_cmd_pkg::queue_entry_t exp_add [$];
   calc_cmd_pkg::queue_entry_t exp_shift [$];
   logic                       exp_rsp [prio_cfg_pkg::NUM_PORTS];
   calc_cmd_pkg::req_tag_t     exp_rsp_tag [prio_cfg_pkg::NUM_PORTS];
   logic                       add_stalled;
   logic                       shift_stalled;

   prio_top u_prio_top (
      .c_clk       (c_clk),
      .arst_n      (arst_n),
      .port_cmd    (port_cmd),
      .cmd_ready   (cmd_ready),
      .invalid_rsp (invalid_rsp),
      .add_out     (add_out),
      .add_valid   (add_valid),
      .shift_out   (shift_out),
      .shift_valid (shift_valid),
      .add_ready   (add_ready),
      .shift_ready (shift_ready)
   );

   initial begin
      c_clk = 1'b0;
      forever #4 c_clk = ~c_clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [71:0] actual,
                              input logic [71:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
      end
   endtask

   // ready codes are 0, 1 or 2 for a random draw
   function automatic logic pick_ready(input logic [1:0] code);
      if (code == 2'd2) begin
         return 1'($urandom);
      end
      return code[0];
   endfunction

   function automatic calc_cmd_pkg::queue_entry_t make_entry(input int port,
                                                             input calc_cmd_pkg::port_cmd_t cmd);
      calc_cmd_pkg::queue_entry_t e;
      e.opcode = cmd.opcode;
      e.port   = port[1:0];
      e.tag    = cmd.tag;
      e.data1  = cmd.data1;
      e.data2  = cmd.data2;
      return e;
   endfunction

   task automatic read_tests();
      int          fd;
      int          n;
      string       text;
      string       rdy [2];
      logic [31:0] f [16];
      fd = $fopen("sim/prio_tests.txt", "r");
      if (fd == 0) begin
         fail_run("could not open the test data file sim/prio_tests.txt");
      end
      while ($fgets(text, fd) > 0) begin
         if (text.len() < 2 || text[0] == "#") begin
            continue;
         end
         n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %s",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                     f[10], f[11], f[12], f[13], f[14], f[15], rdy[0], rdy[1]);
         if (n != 18 || num_lines >= MAX_LINES) begin
            fail_run("the test data holds a malformed line or too many lines");
         end
         for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
            line_cmd[num_lines][k].opcode = f[4*k][3:0];
            line_cmd[num_lines][k].tag    = f[4*k+1][1:0];
            line_cmd[num_lines][k].data1  = f[4*k+2];
            line_cmd[num_lines][k].data2  = f[4*k+3];
         end
         for (int j = 0; j < 2; j++) begin
            line_rdy[num_lines][j] = (rdy[j] == "rnd") ? 2'd2 : {1'b0, rdy[j] == "1"};
         end
         num_lines++;
      end
      $fclose(fd);
   endtask

   // a held line keeps its commands while the unit readies are redrawn
   task automatic drive_line(input int idx, input logic hold);
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         if (idx < num_lines) begin
            port_cmd[k] <= line_cmd[idx][k];
         end else begin
            port_cmd[k] <= '0;
         end
      end
      if (idx >= num_lines) begin
         add_ready   <= 1'b1;
         shift_ready <= 1'b1;
      end else begin
         add_ready   <= pick_ready(hold ? 2'd2 : line_rdy[idx][0]);
         shift_ready <= pick_ready(hold ? 2'd2 : line_rdy[idx][1]);
      end
   endtask

   // runs between edges, where every DUT signal is settled for the next edge
   task automatic observe_cycle();
      calc_cmd_pkg::opcode_t op;
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         check_value($sformatf("invalid_rsp[%0d].valid", k), invalid_rsp[k].valid, exp_rsp[k]);
         if (exp_rsp[k]) begin
            check_value($sformatf("invalid_rsp[%0d].tag", k), invalid_rsp[k].tag, exp_rsp_tag[k]);
         end
      end
      check_value("cmd_ready", cmd_ready,
                  exp_add.size() <= prio_cfg_pkg::QUEUE_DEPTH - prio_cfg_pkg::NUM_PORTS &&
                  exp_shift.size() <= prio_cfg_pkg::QUEUE_DEPTH - prio_cfg_pkg::NUM_PORTS);
      if (add_stalled) begin
         check_value("add_valid", add_valid, 1'b1);
      end
      if (shift_stalled) begin
         check_value("shift_valid", shift_valid, 1'b1);
      end
      if (add_valid) begin
         if (exp_add.size() == 0) begin
            fail_run("the adder was offered a command that was never sent to it");
         end
         check_value("add_out", add_out, exp_add[0]);
      end
      if (shift_valid) begin
         if (exp_shift.size() == 0) begin
            fail_run("the shifter was offered a command that was never sent to it");
         end
         check_value("shift_out", shift_out, exp_shift[0]);
      end
      if (add_valid && shift_valid) begin
         check_value("same_port_pair", add_out.port == shift_out.port, 1'b0);
      end
      if (add_valid && add_ready) begin
         void'(exp_add.pop_front());
      end
      if (shift_valid && shift_ready) begin
         void'(exp_shift.pop_front());
      end
      add_stalled   = add_valid && !add_ready;
      shift_stalled = shift_valid && !shift_ready;
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         op             = port_cmd[k].opcode;
         exp_rsp[k]     = 1'b0;
         exp_rsp_tag[k] = port_cmd[k].tag;
         if (cmd_ready) begin
            if (op == calc_cmd_pkg::OP_ADD || op == calc_cmd_pkg::OP_SUB) begin
               exp_add.push_back(make_entry(k, port_cmd[k]));
            end else if (op == calc_cmd_pkg::OP_SHL || op == calc_cmd_pkg::OP_SHR) begin
               exp_shift.push_back(make_entry(k, port_cmd[k]));
            end else if (op != calc_cmd_pkg::OP_NONE) begin
               exp_rsp[k] = 1'b1;
            end
         end
      end
   endtask

   always @(posedge c_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > num_lines * 40 + 100) begin
         fail_run($sformatf("timeout after %0d cycles with commands still pending", cycle_count));
      end
   end

   initial begin
      int   line;
      logic hold;
      void'($urandom(32'h433e_80b1));
      arst_n      = 1'b0;
      add_ready   = 1'b0;
      shift_ready = 1'b0;
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         port_cmd[k]    = '0;
         exp_rsp[k]     = 1'b0;
         exp_rsp_tag[k] = '0;
      end
      add_stalled   = 1'b0;
      shift_stalled = 1'b0;
      read_tests();
      repeat (10) @(posedge c_clk);
      arst_n <= 1'b1;
      @(negedge c_clk);
      check_value("add_valid", add_valid, 1'b0);
      check_value("shift_valid", shift_valid, 1'b0);
      check_value("cmd_ready", cmd_ready, 1'b1);
      for (int k = 0; k < prio_cfg_pkg::NUM_PORTS; k++) begin
         check_value($sformatf("invalid_rsp[%0d].valid", k), invalid_rsp[k].valid, 1'b0);
      end
      line = 0;
      hold = 1'b0;
      while (line < num_lines || exp_add.size() != 0 || exp_shift.size() != 0) begin
         @(posedge c_clk);
         drive_line(line, hold);
         @(negedge c_clk);
         observe_cycle();
         hold = !cmd_ready;
         if (line < num_lines && cmd_ready) begin
            line++;
         end
      end
      // both units stay quiet once everything has drained
      repeat (4) begin
         @(posedge c_clk);
         drive_line(num_lines, 1'b0);
         @(negedge c_clk);
         observe_cycle();
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
source/calc_cmd_pkg.sv
source/prio_cfg_pkg.sv
source/cmd_sorter.sv
source/cmd_queue.sv
source/dispatch_arbiter.sv
source/prio_top.sv
sim/prio_tb.sv

/* Bender.yml */
package:
  name: prio_stage

sources:
  - source/calc_cmd_pkg.sv
  - source/prio_cfg_pkg.sv
  - source/cmd_sorter.sv
  - source/cmd_queue.sv
  - source/dispatch_arbiter.sv
  - source/prio_top.sv
  - target: simulation
    files:
      - sim/prio_tb.sv

/* sim/prio_tests.txt */
# ports 1..4 as opcode tag data1 data2 in hex, then add_ready shift_ready as 0, 1 or rnd
# opcodes 1 and 2 add, 5 and 6 shift, 0 idle, any other value is rejected
1 0 00000001 00000002 2 1 00000010 00000020 5 2 00000100 00000003 6 3 80000000 00000004 1 1
0 0 00000000 00000000 3 1 deadbeef 00000000 1 2 00000005 00000006 f 3 12345678 9abcdef0 1 1
1 1 aaaaaaaa 00000001 0 0 00000000 00000000 0 0 00000000 00000000 0 0 00000000 00000000 0 0
5 2 bbbbbbbb 00000002 6 0 0000cafe 00000008 0 0 00000000 00000000 0 0 00000000 00000000 0 0
2 3 cccccccc 00000003 1 0 00000007 00000009 0 0 00000000 00000000 0 0 00000000 00000000 1 1
6 1 dddddddd 00000004 0 0 00000000 00000000 2 2 0000abcd 00001234 9 0 00000000 00000000 1 0
0 0 00000000 00000000 0 0 00000000 00000000 0 0 00000000 00000000 0 0 00000000 00000000 0 1
1 0 11111111 00000001 2 1 22222222 00000002 1 2 33333333 00000003 2 3 44444444 00000004 0 0
2 0 55555555 00000005 1 1 66666666 00000006 2 2 77777777 00000007 1 3 88888888 00000008 0 0
1 1 99999999 00000009 1 2 a0a0a0a0 0000000a 2 3 b0b0b0b0 0000000b 1 0 c0c0c0c0 0000000c 0 0
2 2 d0d0d0d0 0000000d 2 3 e0e0e0e0 0000000e 1 0 f0f0f0f0 0000000f 2 1 01010101 00000010 0 0
5 0 02020202 00000001 6 1 03030303 00000002 5 2 04040404 00000003 6 3 05050505 00000004 0 0
6 3 06060606 0000001f 5 2 07070707 00000011 c 1 00000000 00000000 5 0 08080808 00000005 rnd rnd
1 2 09090909 0000000a 6 1 0a0a0a0a 00000002 2 0 0b0b0b0b 0000000c 7 2 00000000 00000000 rnd rnd
5 1 0c0c0c0c 00000003 1 3 0d0d0d0d 0000000e 6 0 0e0e0e0e 00000006 2 1 0f0f0f0f 00000010 rnd 1
0 0 00000000 00000000 e 3 00000000 00000000 0 0 00000000 00000000 6 2 10101010 00000007 1 rnd
